//--- src/gat_pkg.sv
package gat_pkg;

  localparam int DATA_WIDTH      = 8;
  localparam int NUM_FEATURE_OUT = 4;

  // Holds an 8x8 product summed over up to 16 terms
  localparam int WH_DATA_WIDTH   = 20;

  localparam int COEF_WIDTH      = 32;
  localparam int COL_IDX_WIDTH   = 6;

  // Slope of the leaky ReLU for negative scores
  localparam int LEAKY_SHIFT     = 3;

  // Signed scalar elements
  typedef logic signed [DATA_WIDTH-1:0]    data_t;
  typedef logic signed [WH_DATA_WIDTH-1:0] wh_data_t;

  typedef data_t    [NUM_FEATURE_OUT-1:0] w_row_t;
  typedef wh_data_t [NUM_FEATURE_OUT-1:0] wh_vec_t;

  // One nonzero of the sparse feature matrix
  typedef struct packed {
    data_t                    value;
    logic [COL_IDX_WIDTH-1:0] col;
    logic                     row_last;
    logic                     graph_last;
  } h_entry_t;

  typedef struct packed {
    wh_vec_t wh;
    logic    first_node;
    logic    graph_last;
  } wh_node_t;

  typedef struct packed {
    w_row_t src;
    w_row_t nbr;
  } attn_vec_t;

endpackage

//--- src/weight_loader.sv
module weight_loader #(
  parameter int NUM_FEATURE_IN = 16
) (
  input  logic                                  clk,
  input  logic                                  rst_n,

  input  logic                                  wgt_vld_i,
  input  logic signed [gat_pkg::DATA_WIDTH-1:0] wgt_data_i,

  input  logic [gat_pkg::COL_IDX_WIDTH-1:0]     rd_col_i,
  output gat_pkg::w_row_t                       w_row_o,

  output gat_pkg::attn_vec_t                    attn_o,
  output logic                                  w_ready_o
);

  // W rows, then one src row and one nbr row
  localparam int NUM_WORDS = (NUM_FEATURE_IN + 2) * gat_pkg::NUM_FEATURE_OUT;
  localparam int CNT_W     = $clog2(NUM_WORDS + 1);
  localparam int ELEM_W    = $clog2(gat_pkg::NUM_FEATURE_OUT);
  localparam int ROW_W     = $clog2(NUM_FEATURE_IN);

  logic [CNT_W-1:0]        word_cnt;
  logic [CNT_W-ELEM_W-1:0] word_row;
  logic [ELEM_W-1:0]       word_elem;
  logic                    wr_en;

  gat_pkg::w_row_t         w_mem [NUM_FEATURE_IN];
  gat_pkg::attn_vec_t      attn_q;

  // Words after the load are dropped
  assign wr_en     = wgt_vld_i && !w_ready_o;
  assign word_row  = word_cnt[CNT_W-1:ELEM_W];
  assign word_elem = word_cnt[ELEM_W-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_cnt  <= '0;
      w_ready_o <= 1'b0;
    end else if (wr_en) begin
      word_cnt <= word_cnt + 1'b1;
      if (word_cnt == CNT_W'(NUM_WORDS - 1)) begin
        w_ready_o <= 1'b1;
      end
    end
  end

  // Row-major fill, rows past W go to the attention vectors
  always_ff @(posedge clk) begin
    if (wr_en) begin
      if (word_row < NUM_FEATURE_IN) begin
        w_mem[word_row[ROW_W-1:0]][word_elem] <= wgt_data_i;
      end else if (word_row == NUM_FEATURE_IN) begin
        attn_q.src[word_elem] <= wgt_data_i;
      end else begin
        attn_q.nbr[word_elem] <= wgt_data_i;
      end
    end
  end

  // Columns beyond the input features read as zero
  assign w_row_o = (rd_col_i < NUM_FEATURE_IN) ? w_mem[rd_col_i[ROW_W-1:0]] : '0;
  assign attn_o  = attn_q;

endmodule

//--- src/spmm_engine.sv
module spmm_engine (
  input  logic                              clk,
  input  logic                              rst_n,

  input  logic                              h_vld_i,
  input  gat_pkg::h_entry_t                 h_entry_i,
  input  logic                              w_ready_i,

  output logic [gat_pkg::COL_IDX_WIDTH-1:0] rd_col_o,
  input  gat_pkg::w_row_t                   w_row_i,

  output logic                              wh_vld_o,
  output gat_pkg::wh_node_t                 wh_node_o
);

  logic             accept;
  logic             first_pend;

  logic             s1_vld;
  gat_pkg::data_t   s1_value;
  gat_pkg::w_row_t  s1_w_row;
  logic             s1_row_last;
  logic             s1_graph_last;
  logic             s1_first;

  gat_pkg::wh_vec_t acc;
  gat_pkg::wh_vec_t acc_sum;

  // Entries before the weights are loaded are dropped
  assign accept   = h_vld_i && w_ready_i;
  assign rd_col_o = h_entry_i.col;

  // Stage 1: entry plus its W row
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld     <= 1'b0;
      first_pend <= 1'b1;
    end else begin
      s1_vld <= accept;
      // Next row opens a new subgraph after graph_last
      if (accept && h_entry_i.row_last) begin
        first_pend <= h_entry_i.graph_last;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      s1_value      <= h_entry_i.value;
      s1_w_row      <= w_row_i;
      s1_row_last   <= h_entry_i.row_last;
      s1_graph_last <= h_entry_i.graph_last;
      s1_first      <= first_pend;
    end
  end

  // Stage 2: multiply-accumulate per output feature
  always_comb begin
    for (int f = 0; f < gat_pkg::NUM_FEATURE_OUT; f++) begin
      acc_sum[f] = acc[f] + s1_value * s1_w_row[f];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc      <= '0;
      wh_vld_o <= 1'b0;
    end else begin
      wh_vld_o <= s1_vld && s1_row_last;
      if (s1_vld) begin
        // Row done, start the next one from zero
        acc <= s1_row_last ? '0 : acc_sum;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s1_vld && s1_row_last) begin
      wh_node_o.wh         <= acc_sum;
      wh_node_o.first_node <= s1_first;
      wh_node_o.graph_last <= s1_graph_last;
    end
  end

endmodule

//--- src/dmvm_engine.sv
module dmvm_engine #(
  parameter int MAX_NODES = 8
) (
  input  logic                                  clk,
  input  logic                                  rst_n,

  input  logic                                  wh_vld_i,
  input  gat_pkg::wh_node_t                     wh_node_i,
  input  gat_pkg::attn_vec_t                    attn_i,

  output logic                                  coef_vld_o,
  output logic signed [gat_pkg::COEF_WIDTH-1:0] coef_o,
  output logic                                  graph_done_o,
  output logic [$clog2(MAX_NODES+1)-1:0]        node_count_o
);

  localparam int CNT_W = $clog2(MAX_NODES + 1);

  typedef logic signed [gat_pkg::COEF_WIDTH-1:0] score_t;

  function automatic score_t dot(input gat_pkg::w_row_t a, input gat_pkg::wh_vec_t v);
    score_t sum;
    sum = '0;
    for (int f = 0; f < gat_pkg::NUM_FEATURE_OUT; f++) begin
      sum = sum + a[f] * v[f];
    end
    return sum;
  endfunction

  logic             s1_vld;
  score_t           s1_src;
  score_t           s1_nbr;
  logic             s1_first;
  logic             s1_graph_last;

  score_t           src_hold;
  score_t           src_base;
  score_t           score;
  logic [CNT_W-1:0] node_cnt;
  logic [CNT_W-1:0] node_cnt_next;

  // Stage 1: both attention dot products
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld <= 1'b0;
    end else begin
      s1_vld <= wh_vld_i;
    end
  end

  always_ff @(posedge clk) begin
    if (wh_vld_i) begin
      s1_src        <= dot(attn_i.src, wh_node_i.wh);
      s1_nbr        <= dot(attn_i.nbr, wh_node_i.wh);
      s1_first      <= wh_node_i.first_node;
      s1_graph_last <= wh_node_i.graph_last;
    end
  end

  // First node scores against itself, so bypass the held value
  assign src_base      = s1_first ? s1_src : src_hold;
  assign score         = src_base + s1_nbr;
  assign node_cnt_next = s1_first ? CNT_W'(1) : node_cnt + 1'b1;

  // Stage 2: leaky ReLU and node count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      coef_vld_o   <= 1'b0;
      graph_done_o <= 1'b0;
      node_cnt     <= '0;
    end else begin
      coef_vld_o   <= s1_vld;
      graph_done_o <= s1_vld && s1_graph_last;
      if (s1_vld) begin
        node_cnt <= node_cnt_next;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s1_vld) begin
      if (s1_first) begin
        src_hold <= s1_src;
      end
      coef_o       <= (score < 0) ? (score >>> gat_pkg::LEAKY_SHIFT) : score;
      node_count_o <= node_cnt_next;
    end
  end

endmodule

//--- src/gat_conv_top.sv
module gat_conv_top #(
  parameter int NUM_FEATURE_IN = 16,
  parameter int MAX_NODES      = 8
) (
  input  logic                                  clk,
  input  logic                                  rst_n,

  input  logic                                  wgt_vld_i,
  input  logic signed [gat_pkg::DATA_WIDTH-1:0] wgt_data_i,

  input  logic                                  h_vld_i,
  input  gat_pkg::h_entry_t                     h_entry_i,

  output logic                                  w_ready_o,

  output logic                                  wh_vld_o,
  output gat_pkg::wh_node_t                     wh_node_o,

  output logic                                  coef_vld_o,
  output logic signed [gat_pkg::COEF_WIDTH-1:0] coef_o,
  output logic                                  graph_done_o,
  output logic [$clog2(MAX_NODES+1)-1:0]        node_count_o
);

  logic [gat_pkg::COL_IDX_WIDTH-1:0] rd_col;
  gat_pkg::w_row_t                   w_row;
  gat_pkg::attn_vec_t                attn;

  // Weight and attention vector store
  weight_loader #(
    .NUM_FEATURE_IN (NUM_FEATURE_IN )
  ) u_weight_loader (
    .clk            (clk            ),
    .rst_n          (rst_n          ),
    .wgt_vld_i      (wgt_vld_i      ),
    .wgt_data_i     (wgt_data_i     ),
    .rd_col_i       (rd_col         ),
    .w_row_o        (w_row          ),
    .attn_o         (attn           ),
    .w_ready_o      (w_ready_o      )
  );

  // Sparse H times W
  spmm_engine u_spmm_engine (
    .clk            (clk            ),
    .rst_n          (rst_n          ),
    .h_vld_i        (h_vld_i        ),
    .h_entry_i      (h_entry_i      ),
    .w_ready_i      (w_ready_o      ),
    .rd_col_o       (rd_col         ),
    .w_row_i        (w_row          ),
    .wh_vld_o       (wh_vld_o       ),
    .wh_node_o      (wh_node_o      )
  );

  // Attention coefficients per subgraph
  dmvm_engine #(
    .MAX_NODES      (MAX_NODES      )
  ) u_dmvm_engine (
    .clk            (clk            ),
    .rst_n          (rst_n          ),
    .wh_vld_i       (wh_vld_o       ),
    .wh_node_i      (wh_node_o      ),
    .attn_i         (attn           ),
    .coef_vld_o     (coef_vld_o     ),
    .coef_o         (coef_o         ),
    .graph_done_o   (graph_done_o   ),
    .node_count_o   (node_count_o   )
  );

endmodule

//--- bench/gat_tb.sv
module gat_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_FEATURE_IN  = 16;
  localparam int MAX_NODES       = 8;
  localparam int NF              = gat_pkg::NUM_FEATURE_OUT;
  localparam int CNT_W           = $clog2(MAX_NODES + 1);
  localparam int CLK_PERIOD      = 8;
  localparam int RESET_CYCLES    = 16;
  localparam int NUM_GRAPHS      = 12;
  localparam int EARLY_ENTRIES   = 6;
  localparam int LOAD_WORDS      = (NUM_FEATURE_IN + 2) * NF;
  localparam int MAX_ENTRIES     = NUM_GRAPHS * MAX_NODES * 4 + EARLY_ENTRIES;
  localparam int LIMIT_CYCLES    = RESET_CYCLES + LOAD_WORDS + 2 + 20 * MAX_ENTRIES;

  typedef logic [gat_pkg::COL_IDX_WIDTH-1:0] col_t;

  logic                                  clk;
  logic                                  rst_n;
  logic                                  wgt_vld;
  logic signed [gat_pkg::DATA_WIDTH-1:0] wgt_data;
  logic                                  h_vld;
  gat_pkg::h_entry_t                     h_entry;
  logic                                  w_ready;
  logic                                  wh_vld;
  gat_pkg::wh_node_t                     wh_node;
  logic                                  coef_vld;
  logic signed [gat_pkg::COEF_WIDTH-1:0] coef;
  logic                                  graph_done;
  logic [CNT_W-1:0]                      node_count;

  logic [31:0] lfsr_state;
  int          cyc = 0;

  // Reference copies of W and the attention vectors
  int w_model [NUM_FEATURE_IN][NF];
  int src_model [NF];
  int nbr_model [NF];

  gat_pkg::wh_node_t wh_exp_q [$];
  int                wh_cyc_q [$];
  int                coef_exp_q [$];
  bit                done_exp_q [$];
  int                count_exp_q [$];
  int                coef_cyc_q [$];

  gat_conv_top #(
    .NUM_FEATURE_IN (NUM_FEATURE_IN),
    .MAX_NODES      (MAX_NODES     )
  ) dut_i (
    .clk            (clk           ),
    .rst_n          (rst_n         ),
    .wgt_vld_i      (wgt_vld       ),
    .wgt_data_i     (wgt_data      ),
    .h_vld_i        (h_vld         ),
    .h_entry_i      (h_entry       ),
    .w_ready_o      (w_ready       ),
    .wh_vld_o       (wh_vld        ),
    .wh_node_o      (wh_node       ),
    .coef_vld_o     (coef_vld      ),
    .coef_o         (coef          ),
    .graph_done_o   (graph_done    ),
    .node_count_o   (node_count    )
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int unsigned rand_bits(input int n);
    int unsigned r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = (r << 1) | int'(lfsr_state[0]);
    end
    return r;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input longint got, input longint exp);
    if (got !== exp) begin
      report_failure($sformatf("** Error at %0t: %s is %0d, expected %0d",
                               $time, what, got, exp));
    end
  endtask

  task automatic drive_entry(input gat_pkg::h_entry_t e);
    @(negedge clk);
    h_vld   = 1'b1;
    h_entry = e;
  endtask

  // Mostly back-to-back, sometimes a short idle stretch
  task automatic insert_gap();
    int gap;
    gap = 0;
    if (rand_bits(2) == 3) begin
      gap = int'(rand_bits(2)) + 1;
    end
    repeat (gap) begin
      @(negedge clk);
      h_vld = 1'b0;
    end
  endtask

  task automatic send_early_entries();
    gat_pkg::h_entry_t e;
    for (int k = 0; k < EARLY_ENTRIES; k++) begin
      e.value      = gat_pkg::data_t'(rand_bits(8));
      e.col        = col_t'(rand_bits(4));
      e.row_last   = rand_bits(1) != 0;
      e.graph_last = rand_bits(1) != 0;
      drive_entry(e);
    end
    @(negedge clk);
    h_vld = 1'b0;
  endtask

  task automatic load_weights();
    logic signed [gat_pkg::DATA_WIDTH-1:0] d;
    // Two extra words past the load must be ignored
    for (int k = 0; k < LOAD_WORDS + 2; k++) begin
      d = gat_pkg::data_t'(rand_bits(8));
      if (k < NUM_FEATURE_IN * NF) begin
        w_model[k / NF][k % NF] = int'(d);
      end else if (k < (NUM_FEATURE_IN + 1) * NF) begin
        src_model[k % NF] = int'(d);
      end else if (k < LOAD_WORDS) begin
        nbr_model[k % NF] = int'(d);
      end
      @(negedge clk);
      if (k > 0) begin
        check_value($sformatf("w_ready_o after word %0d", k - 1), w_ready,
                    (k - 1 >= LOAD_WORDS - 1));
      end
      wgt_vld  = 1'b1;
      wgt_data = d;
    end
    @(negedge clk);
    wgt_vld = 1'b0;
    check_value("w_ready_o after the last word", w_ready, 1);
  endtask

  task automatic send_graphs();
    gat_pkg::h_entry_t e;
    gat_pkg::wh_node_t exp_node;
    int                nodes;
    int                len;
    int                wh_acc [NF];
    int                src_first;
    int                src_this;
    int                nbr_this;
    int                score;
    src_first = 0;
    for (int g = 0; g < NUM_GRAPHS; g++) begin
      nodes = int'(rand_bits(3)) + 1;
      for (int n = 0; n < nodes; n++) begin
        len = int'(rand_bits(2)) + 1;
        for (int f = 0; f < NF; f++) wh_acc[f] = 0;
        for (int k = 0; k < len; k++) begin
          e.value      = gat_pkg::data_t'(rand_bits(8));
          e.col        = col_t'(rand_bits(4));
          e.row_last   = (k == len - 1);
          e.graph_last = (k == len - 1) && (n == nodes - 1);
          for (int f = 0; f < NF; f++) begin
            wh_acc[f] += int'(e.value) * w_model[e.col][f];
          end
          insert_gap();
          drive_entry(e);
        end
        // Still at the negedge that drove the row_last entry
        src_this = 0;
        nbr_this = 0;
        for (int f = 0; f < NF; f++) begin
          exp_node.wh[f] = gat_pkg::wh_data_t'(wh_acc[f]);
          src_this += src_model[f] * wh_acc[f];
          nbr_this += nbr_model[f] * wh_acc[f];
        end
        exp_node.first_node = (n == 0);
        exp_node.graph_last = (n == nodes - 1);
        wh_exp_q.push_back(exp_node);
        wh_cyc_q.push_back(cyc + 2);
        if (n == 0) src_first = src_this;
        score = src_first + nbr_this;
        coef_exp_q.push_back((score < 0) ? (score >>> gat_pkg::LEAKY_SHIFT) : score);
        done_exp_q.push_back(n == nodes - 1);
        count_exp_q.push_back(n + 1);
        coef_cyc_q.push_back(cyc + 4);
      end
    end
    @(negedge clk);
    h_vld = 1'b0;
  endtask

  task automatic check_wh();
    gat_pkg::wh_node_t exp_node;
    if (wh_exp_q.size() == 0) begin
      report_failure("Wh output strobed while no row was pending");
    end else begin
      exp_node = wh_exp_q.pop_front();
      check_value("wh_vld_o cycle", cyc, wh_cyc_q.pop_front());
      for (int f = 0; f < NF; f++) begin
        check_value($sformatf("Wh element %0d", f), wh_node.wh[f], exp_node.wh[f]);
      end
      check_value("first_node", wh_node.first_node, exp_node.first_node);
      check_value("graph_last", wh_node.graph_last, exp_node.graph_last);
    end
  endtask

  task automatic check_coef();
    if (coef_exp_q.size() == 0) begin
      report_failure("Coefficient strobed while no node was pending");
    end else begin
      check_value("coef_vld_o cycle", cyc, coef_cyc_q.pop_front());
      check_value("coef_o", coef, coef_exp_q.pop_front());
      check_value("graph_done_o", graph_done, done_exp_q.pop_front());
      check_value("node_count_o", node_count, count_exp_q.pop_front());
    end
  endtask

  // Outputs are registered, so the falling edge sees them settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (wh_vld) check_wh();
      if (coef_vld) begin
        check_coef();
      end else if (graph_done) begin
        report_failure("graph_done_o went high without a coefficient");
      end
    end
  end

  initial begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    report_failure($sformatf("Timeout: %0d Wh results and %0d coefficients never arrived",
                             wh_exp_q.size(), coef_exp_q.size()));
  end

  initial begin
    lfsr_state = 32'h01fb_f3ee;
    rst_n      = 1'b0;
    wgt_vld    = 1'b0;
    wgt_data   = '0;
    h_vld      = 1'b0;
    h_entry    = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("w_ready_o after reset", w_ready, 0);

    send_early_entries();
    load_weights();
    send_graphs();

    // Last coefficient is due four edges after its entry, the rest catch stray strobes
    repeat (8) @(negedge clk);

    if (wh_exp_q.size() != 0 || coef_exp_q.size() != 0) begin
      report_failure("Expected results were left over at the end of the run");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

//--- compile.f
src/gat_pkg.sv
src/weight_loader.sv
src/spmm_engine.sv
src/dmvm_engine.sv
src/gat_conv_top.sv
bench/gat_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the GAT front end with Verilator and run its testbench

set -u

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project directory"
  exit 1
fi

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator was not found in PATH"
  exit 1
fi

verilator --binary -j 0 -Wno-fatal --top-module gat_tb -f compile.f -o gat_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/gat_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx '>>> PASS' <<< "$sim_out"; then
  exit 0
fi
echo "Simulation did not report a pass"
exit 1
